/* dv/mem_subsys_testdata.txt */
// op_size_strb_addr_addr2_wdata_exp1_exp2_exp3 (op 1 fetch, 2 load, 3 store, 4 fetch and load)
// fetch uses addr, exp1 and exp2; a load uses addr (addr2 for op 4) and exp3
1_2_0_00000100_00000000_00000000_5a5a0100_5a5a0104_00000000
1_2_0_00001238_00000000_00000000_5a5a1238_5a5a123c_00000000
2_2_f_00000200_00000000_00000000_00000000_00000000_5a5a0200
3_0_2_00000305_00000000_0000cd00_00000000_00000000_00000000
2_2_f_00000304_00000000_00000000_00000000_00000000_5a5acd04
3_1_c_00000412_00000000_beef0000_00000000_00000000_00000000
2_1_c_00000412_00000000_00000000_00000000_00000000_beef0410
2_0_8_00000413_00000000_00000000_00000000_00000000_beef0410
3_2_f_00000500_00000000_12345678_00000000_00000000_00000000
2_0_1_00000500_00000000_00000000_00000000_00000000_12345678
4_2_f_00000600_00000708_00000000_5a5a0600_5a5a0604_5a5a0708
4_2_f_00000500_00000304_00000000_12345678_5a5a0504_5a5acd04
3_2_5_00000604_00000000_aabbccdd_00000000_00000000_00000000
4_2_f_00000600_00000604_00000000_5a5a0600_5abb06dd_5abb06dd
4_2_f_00002ff8_00002ffc_00000000_5a5a2ff8_5a5a2ffc_5a5a2ffc

/* project.f */
+incdir+source
source/mem_pkg.sv
source/inst_fetcher.sv
source/sram_to_axi.sv
source/axi_read_arbiter.sv
source/mem_subsys_top.sv
dv/mem_subsys_assertions.sv
dv/tb_mem_subsys.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_mem_subsys
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the log decides pass or fail
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* dv/tb_mem_subsys.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module tb_mem_subsys import mem_pkg::*; ();

	localparam int PERIOD = 100;
	localparam int MAX_OPS = 32;
	localparam int OP_CYCLES = 40;
	localparam logic [3:0] OP_FETCH = 4'd1;
	localparam logic [3:0] OP_LOAD = 4'd2;
	localparam logic [3:0] OP_STORE = 4'd3;
	localparam logic [3:0] OP_BOTH = 4'd4;

	// one line of the data file
	typedef struct packed {
		logic [3:0] op;
		logic [3:0] size;
		strb_t      strb;
		addr_t      addr;
		addr_t      addr2;
		word_t      wdata;
		word_t      exp1;
		word_t      exp2;
		word_t      exp3;
	} vec_t;

	logic      aclk = 1'b0;
	logic      arst_n_i;
	logic      fetch_req_i;
	addr_t     fetch_addr_i;
	logic      fetch_stall_o;
	logic      fetch_valid_o;
	word_t     inst1_o;
	word_t     inst2_o;
	logic      data_en_i;
	data_req_t data_req_i;
	logic      data_stall_o;
	logic      data_done_o;
	word_t     data_rdata_o;
	ar_t       m_ar_o;
	logic      m_ar_valid_o;
	logic      m_ar_ready_i;
	r_t        m_r_i;
	logic      m_r_valid_i;
	logic      m_r_ready_o;
	aw_t       m_aw_o;
	logic      m_aw_valid_o;
	logic      m_aw_ready_i;
	w_t        m_w_o;
	logic      m_w_valid_o;
	logic      m_w_ready_i;
	b_t        m_b_i;
	logic      m_b_valid_i;
	logic      m_b_ready_o;

	vec_t vecs [MAX_OPS];
	int n_ops = 0;
	int errors = 0;
	int tests = 0;
	int failed = 0;

	// bus model state
	logic [31:0] lfsr = 32'h214d_13ab;
	word_t mem [addr_t];
	ar_t rd_q [$];
	axi_len_t beat;
	logic [1:0] lat;
	logic lat_set;
	aw_t aw_hold;
	w_t w_hold;
	logic aw_have;
	logic w_have;
	logic bus_live;
	logic ar_fire;
	logic r_fire;
	logic aw_fire;
	logic w_fire;
	logic b_fire;
	ar_t ar_pay;
	aw_t aw_pay;
	w_t w_pay;
	axi_len_t fetch_len_seen;
	axi_size_t data_size_seen;
	axi_size_t aw_size_seen;

	mem_subsys_top mem_subsys_top_i (.*);

	always #(PERIOD / 2) aclk = ~aclk;

	function automatic logic next_rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 32'hb4bc_d35c;
		end
		return b;
	endfunction

	// untouched words read back as address xor pattern
	function automatic word_t mem_read(input addr_t a);
		addr_t key;
		key = {a[31:2], 2'b00};
		if (mem.exists(key)) begin
			return mem[key];
		end
		return key ^ 32'h5a5a_0000;
	endfunction

	function automatic void mem_write(input addr_t a, input word_t d, input strb_t s);
		word_t cur;
		cur = mem_read(a);
		for (int i = 0; i < 4; i++) begin
			if (s[i]) begin
				cur[i*8 +: 8] = d[i*8 +: 8];
			end
		end
		mem[{a[31:2], 2'b00}] = cur;
	endfunction

	function automatic string op_name(input logic [3:0] op);
		case (op)
			OP_FETCH: return "fetch";
			OP_LOAD:  return "load";
			OP_STORE: return "store";
			default:  return "fetch+load";
		endcase
	endfunction

	task automatic check_value(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("FAILED at %0t ns: %s got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic bus_step();
		if (ar_fire) begin
			rd_q.push_back(ar_pay);
			if (ar_pay.id == axi_id_t'(`MEM_ID_FETCH)) begin
				fetch_len_seen = ar_pay.len;
			end else begin
				data_size_seen = ar_pay.size;
			end
		end
		if (r_fire) begin
			m_r_valid_i = 1'b0;
			if (m_r_i.last) begin
				rd_q.delete(0);
				beat = '0;
				lat_set = 1'b0;
			end else begin
				beat = beat + 4'd1;
			end
		end
		// reads are served in arrival order
		if (!m_r_valid_i && rd_q.size() > 0) begin
			if (!lat_set) begin
				lat = {next_rand_bit(), next_rand_bit()};
				lat_set = 1'b1;
			end
			if (lat == 2'd0) begin
				m_r_i = '{id: rd_q[0].id, data: mem_read(rd_q[0].addr + (addr_t'(beat) << 2)),
					resp: 2'b00, last: (beat == rd_q[0].len)};
				m_r_valid_i = 1'b1;
			end else begin
				lat = lat - 2'd1;
			end
		end
		if (aw_fire) begin
			aw_hold = aw_pay;
			aw_have = 1'b1;
			aw_size_seen = aw_pay.size;
		end
		if (w_fire) begin
			w_hold = w_pay;
			w_have = 1'b1;
		end
		if (b_fire) begin
			m_b_valid_i = 1'b0;
		end
		if (aw_have && w_have && !m_b_valid_i) begin
			mem_write(aw_hold.addr, w_hold.data, w_hold.strb);
			m_b_i = '{id: aw_hold.id, resp: 2'b00};
			m_b_valid_i = 1'b1;
			aw_have = 1'b0;
			w_have = 1'b0;
		end
		m_ar_ready_i = next_rand_bit();
		m_aw_ready_i = next_rand_bit() && !aw_have;
		m_w_ready_i = next_rand_bit() && !w_have;
	endtask

	// bus slave, samples at the falling edge and drives after the rising one
	initial begin
		m_ar_ready_i = 1'b0;
		m_r_i = '0;
		m_r_valid_i = 1'b0;
		m_aw_ready_i = 1'b0;
		m_w_ready_i = 1'b0;
		m_b_i = '0;
		m_b_valid_i = 1'b0;
		beat = '0;
		lat = '0;
		lat_set = 1'b0;
		aw_have = 1'b0;
		w_have = 1'b0;
		bus_live = 1'b0;
		forever begin
			@(negedge aclk);
			bus_live = arst_n_i;
			ar_fire = m_ar_valid_o && m_ar_ready_i;
			r_fire = m_r_valid_i && m_r_ready_o;
			aw_fire = m_aw_valid_o && m_aw_ready_i;
			w_fire = m_w_valid_o && m_w_ready_i;
			b_fire = m_b_valid_i && m_b_ready_o;
			ar_pay = m_ar_o;
			aw_pay = m_aw_o;
			w_pay = m_w_o;
			@(posedge aclk);
			#1;
			if (bus_live) begin
				bus_step();
			end
		end
	end

	task automatic run_op(input int idx);
		vec_t v;
		logic want_f;
		logic want_d;
		logic got_f;
		logic got_d;
		word_t i1;
		word_t i2;
		word_t rd;
		int n;
		int err_start;
		v = vecs[idx];
		err_start = errors;
		want_f = (v.op == OP_FETCH) || (v.op == OP_BOTH);
		want_d = (v.op != OP_FETCH);
		got_f = 1'b0;
		got_d = 1'b0;
		i1 = '0;
		i2 = '0;
		rd = '0;
		@(posedge aclk);
		#1;
		fetch_req_i = want_f;
		fetch_addr_i = v.addr;
		data_en_i = want_d;
		data_req_i = '{addr: (v.op == OP_BOTH) ? v.addr2 : v.addr, wdata: v.wdata,
			strb: v.strb, size: v.size[2:0], wr: (v.op == OP_STORE)};
		// both blocks idle, so taken at this edge
		@(posedge aclk);
		#1;
		fetch_req_i = 1'b0;
		data_en_i = 1'b0;
		n = 0;
		while (((want_f && !got_f) || (want_d && !got_d)) && n < OP_CYCLES) begin
			@(negedge aclk);
			// busy from acceptance until the result arrives
			if (want_f && !got_f && !fetch_valid_o) begin
				check_value("fetch_stall_o", word_t'(fetch_stall_o), 32'd1);
			end
			if (want_d && !got_d && !data_done_o) begin
				check_value("data_stall_o", word_t'(data_stall_o), 32'd1);
			end
			if (fetch_valid_o) begin
				got_f = 1'b1;
				i1 = inst1_o;
				i2 = inst2_o;
			end
			if (data_done_o) begin
				got_d = 1'b1;
				rd = data_rdata_o;
			end
			n++;
		end
		if (want_f) begin
			assert (got_f) else begin
				$display("fetch from %h never raised fetch_valid_o", v.addr);
				errors++;
			end
			if (got_f) begin
				check_value("inst1_o", i1, v.exp1);
				check_value("inst2_o", i2, v.exp2);
				check_value("m_ar_o.len", word_t'(fetch_len_seen), 32'd1);
			end
		end
		if (want_d) begin
			assert (got_d) else begin
				$display("data access at %h never raised data_done_o", data_req_i.addr);
				errors++;
			end
			if (got_d && v.op == OP_STORE) begin
				check_value("m_aw_o.size", word_t'(aw_size_seen), word_t'(v.size[2:0]));
			end
			if (got_d && v.op != OP_STORE) begin
				check_value("data_rdata_o", rd, v.exp3);
				check_value("m_ar_o.size", word_t'(data_size_seen), word_t'(v.size[2:0]));
			end
		end
		tests++;
		if (errors != err_start) begin
			failed++;
		end
		$display("op %0d %s at %h: %s", idx, op_name(v.op), v.addr,
			(errors == err_start) ? "ok" : "mismatch");
	endtask

	initial begin
		int count;
		arst_n_i = 1'b0;
		fetch_req_i = 1'b0;
		fetch_addr_i = '0;
		data_en_i = 1'b0;
		data_req_i = '0;
		for (int i = 0; i < MAX_OPS; i++) begin
			vecs[i] = '0;
		end
		$readmemh("dv/mem_subsys_testdata.txt", vecs);
		count = 0;
		while (count < MAX_OPS && vecs[count].op != 4'd0) begin
			count++;
		end
		n_ops = count;
		repeat (2) @(posedge aclk);
		#1;
		arst_n_i = 1'b1;
		@(negedge aclk);
		check_value("stalls, valids, dones, rready, bready", word_t'({fetch_stall_o,
			fetch_valid_o, data_stall_o, data_done_o, m_ar_valid_o, m_aw_valid_o,
			m_w_valid_o, m_r_ready_o, m_b_ready_o}), '0);
		tests++;
		failed += (errors != 0) ? 1 : 0;
		$display("reset state: %s", (errors == 0) ? "ok" : "mismatch");
		assert (n_ops > 0) else begin
			$display("no operations were read from the data file");
			errors++;
		end
		for (int i = 0; i < n_ops; i++) begin
			run_op(i);
		end
		if (mem_subsys_top_i.mem_subsys_assertions_i.fail_count != 0) begin
			$display("bus protocol assertions failed %0d times",
				mem_subsys_top_i.mem_subsys_assertions_i.fail_count);
			errors += mem_subsys_top_i.mem_subsys_assertions_i.fail_count;
		end
		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// forty cycles per operation plus reset slack
	initial begin
		wait (n_ops > 0);
		#((n_ops * OP_CYCLES + 10) * PERIOD);
		$display("watchdog expired before all operations completed");
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* dv/mem_subsys_assertions.sv */
`timescale 1ns/1ps

module mem_subsys_assertions import mem_pkg::*; (
	input logic aclk,
	input logic arst_n_i,
	input ar_t  ar_i,
	input logic ar_valid_i,
	input logic ar_ready_i,
	input aw_t  aw_i,
	input logic aw_valid_i,
	input logic aw_ready_i,
	input w_t   w_i,
	input logic w_valid_i,
	input logic w_ready_i,
	input logic fetch_stall_i,
	input logic fetch_valid_i
);

	int fail_count = 0;

	// valid and payload held until the handshake
	ar_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
		ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
		else begin
			fail_count++;
			$error("ar valid or payload changed before arready");
		end

	aw_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
		aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
		else begin
			fail_count++;
			$error("aw valid or payload changed before awready");
		end

	w_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
		w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
		else begin
			fail_count++;
			$error("w valid or payload changed before wready");
		end

	stall_valid_excl: assert property (@(posedge aclk) disable iff (!arst_n_i)
		!(fetch_stall_i && fetch_valid_i))
		else begin
			fail_count++;
			$error("fetch stall and fetch valid high together");
		end

endmodule

bind mem_subsys_top mem_subsys_assertions mem_subsys_assertions_i (
	.aclk          (aclk),
	.arst_n_i      (arst_n_i),
	.ar_i          (m_ar_o),
	.ar_valid_i    (m_ar_valid_o),
	.ar_ready_i    (m_ar_ready_i),
	.aw_i          (m_aw_o),
	.aw_valid_i    (m_aw_valid_o),
	.aw_ready_i    (m_aw_ready_i),
	.w_i           (m_w_o),
	.w_valid_i     (m_w_valid_o),
	.w_ready_i     (m_w_ready_i),
	.fetch_stall_i (fetch_stall_o),
	.fetch_valid_i (fetch_valid_o)
);

/* source/mem_subsys_top.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_subsys_top import mem_pkg::*; (
	input  logic      aclk,
	input  logic      arst_n_i,
	input  logic      fetch_req_i,
	input  addr_t     fetch_addr_i,
	output logic      fetch_stall_o,
	output logic      fetch_valid_o,
	output word_t     inst1_o,
	output word_t     inst2_o,
	input  logic      data_en_i,
	input  data_req_t data_req_i,
	output logic      data_stall_o,
	output logic      data_done_o,
	output word_t     data_rdata_o,
	output ar_t       m_ar_o,
	output logic      m_ar_valid_o,
	input  logic      m_ar_ready_i,
	input  r_t        m_r_i,
	input  logic      m_r_valid_i,
	output logic      m_r_ready_o,
	output aw_t       m_aw_o,
	output logic      m_aw_valid_o,
	input  logic      m_aw_ready_i,
	output w_t        m_w_o,
	output logic      m_w_valid_o,
	input  logic      m_w_ready_i,
	input  b_t        m_b_i,
	input  logic      m_b_valid_i,
	output logic      m_b_ready_o
);

	ar_t  fetch_ar;
	logic fetch_ar_valid;
	logic fetch_ar_ready;
	logic fetch_r_valid;
	logic fetch_r_ready;
	ar_t  data_ar;
	logic data_ar_valid;
	logic data_ar_ready;
	logic data_r_valid;
	logic data_r_ready;

	inst_fetcher inst_fetcher_i (
		.aclk          (aclk),
		.arst_n_i      (arst_n_i),
		.fetch_req_i   (fetch_req_i),
		.fetch_addr_i  (fetch_addr_i),
		.fetch_stall_o (fetch_stall_o),
		.fetch_valid_o (fetch_valid_o),
		.inst1_o       (inst1_o),
		.inst2_o       (inst2_o),
		.ar_o          (fetch_ar),
		.ar_valid_o    (fetch_ar_valid),
		.ar_ready_i    (fetch_ar_ready),
		.r_i           (m_r_i),
		.r_valid_i     (fetch_r_valid),
		.r_ready_o     (fetch_r_ready)
	);

	// write channels go straight to the bus
	sram_to_axi sram_to_axi_i (
		.aclk         (aclk),
		.arst_n_i     (arst_n_i),
		.data_en_i    (data_en_i),
		.data_req_i   (data_req_i),
		.data_stall_o (data_stall_o),
		.data_done_o  (data_done_o),
		.data_rdata_o (data_rdata_o),
		.ar_o         (data_ar),
		.ar_valid_o   (data_ar_valid),
		.ar_ready_i   (data_ar_ready),
		.r_i          (m_r_i),
		.r_valid_i    (data_r_valid),
		.r_ready_o    (data_r_ready),
		.aw_o         (m_aw_o),
		.aw_valid_o   (m_aw_valid_o),
		.aw_ready_i   (m_aw_ready_i),
		.w_o          (m_w_o),
		.w_valid_o    (m_w_valid_o),
		.w_ready_i    (m_w_ready_i),
		.b_i          (m_b_i),
		.b_valid_i    (m_b_valid_i),
		.b_ready_o    (m_b_ready_o)
	);

	axi_read_arbiter axi_read_arbiter_i (
		.aclk             (aclk),
		.arst_n_i         (arst_n_i),
		.fetch_ar_i       (fetch_ar),
		.fetch_ar_valid_i (fetch_ar_valid),
		.fetch_ar_ready_o (fetch_ar_ready),
		.fetch_r_valid_o  (fetch_r_valid),
		.fetch_r_ready_i  (fetch_r_ready),
		.data_ar_i        (data_ar),
		.data_ar_valid_i  (data_ar_valid),
		.data_ar_ready_o  (data_ar_ready),
		.data_r_valid_o   (data_r_valid),
		.data_r_ready_i   (data_r_ready),
		.r_i              (m_r_i),
		.m_ar_o           (m_ar_o),
		.m_ar_valid_o     (m_ar_valid_o),
		.m_ar_ready_i     (m_ar_ready_i),
		.m_r_valid_i      (m_r_valid_i),
		.m_r_ready_o      (m_r_ready_o)
	);

endmodule

/* source/axi_read_arbiter.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module axi_read_arbiter import mem_pkg::*; (
	input  logic aclk,
	input  logic arst_n_i,
	input  ar_t  fetch_ar_i,
	input  logic fetch_ar_valid_i,
	output logic fetch_ar_ready_o,
	output logic fetch_r_valid_o,
	input  logic fetch_r_ready_i,
	input  ar_t  data_ar_i,
	input  logic data_ar_valid_i,
	output logic data_ar_ready_o,
	output logic data_r_valid_o,
	input  logic data_r_ready_i,
	input  r_t   r_i,
	output ar_t  m_ar_o,
	output logic m_ar_valid_o,
	input  logic m_ar_ready_i,
	input  logic m_r_valid_i,
	output logic m_r_ready_o
);

	// sel and prio: 0 is the fetcher, 1 the bridge
	logic prio_q;
	logic lock_q;
	logic lock_sel_q;
	logic sel;
	logic to_data;

	always_comb begin
		if (lock_q) begin
			sel = lock_sel_q;
		end else if (fetch_ar_valid_i && data_ar_valid_i) begin
			sel = prio_q;
		end else begin
			sel = data_ar_valid_i;
		end
	end

	assign m_ar_o           = sel ? data_ar_i : fetch_ar_i;
	assign m_ar_valid_o     = sel ? data_ar_valid_i : fetch_ar_valid_i;
	assign fetch_ar_ready_o = !sel && m_ar_ready_i;
	assign data_ar_ready_o  = sel && m_ar_ready_i;

	// return path steered by rid
	assign to_data         = (r_i.id != axi_id_t'(`MEM_ID_FETCH));
	assign fetch_r_valid_o = m_r_valid_i && !to_data;
	assign data_r_valid_o  = m_r_valid_i && to_data;
	assign m_r_ready_o     = to_data ? data_r_ready_i : fetch_r_ready_i;

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			prio_q     <= 1'b0;
			lock_q     <= 1'b0;
			lock_sel_q <= 1'b0;
		end else begin
			if (m_ar_valid_o && m_ar_ready_i) begin
				lock_q <= 1'b0;
				// other master goes first next time
				prio_q <= ~sel;
			end else if (m_ar_valid_o) begin
				// keep the pending ar stable on the bus
				lock_q     <= 1'b1;
				lock_sel_q <= sel;
			end
		end
	end

endmodule

/* source/sram_to_axi.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module sram_to_axi import mem_pkg::*; (
	input  logic      aclk,
	input  logic      arst_n_i,
	input  logic      data_en_i,
	input  data_req_t data_req_i,
	output logic      data_stall_o,
	output logic      data_done_o,
	output word_t     data_rdata_o,
	output ar_t       ar_o,
	output logic      ar_valid_o,
	input  logic      ar_ready_i,
	input  r_t        r_i,
	input  logic      r_valid_i,
	output logic      r_ready_o,
	output aw_t       aw_o,
	output logic      aw_valid_o,
	input  logic      aw_ready_i,
	output w_t        w_o,
	output logic      w_valid_o,
	input  logic      w_ready_i,
	input  b_t        b_i,
	input  logic      b_valid_i,
	output logic      b_ready_o
);

	bridge_state_e state_q;
	data_req_t req_q;
	word_t rdata_q;
	logic done_q;
	logic aw_done_q;
	logic w_done_q;
	logic accept;
	logic aw_fire;
	logic w_fire;
	logic aw_ok;
	logic w_ok;

	assign accept  = (state_q == BR_IDLE) && data_en_i;
	assign aw_fire = aw_valid_o && aw_ready_i;
	assign w_fire  = w_valid_o && w_ready_i;
	assign aw_ok   = aw_done_q || aw_fire;
	assign w_ok    = w_done_q || w_fire;

	// single beat, same id for reads and writes
	assign ar_o = '{
		id:   axi_id_t'(`MEM_ID_DATA),
		addr: req_q.addr,
		len:  axi_len_t'(0),
		size: req_q.size
	};
	assign aw_o = ar_o;
	assign w_o  = '{data: req_q.wdata, strb: req_q.strb, last: 1'b1};

	assign ar_valid_o = (state_q == BR_RADDR);
	assign r_ready_o  = (state_q == BR_RDATA);
	assign aw_valid_o = (state_q == BR_WRITE) && !aw_done_q;
	assign w_valid_o  = (state_q == BR_WRITE) && !w_done_q;
	assign b_ready_o  = (state_q == BR_WRESP);

	assign data_stall_o = (state_q != BR_IDLE);
	assign data_done_o  = done_q;
	assign data_rdata_o = rdata_q;

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q   <= BR_IDLE;
			done_q    <= 1'b0;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				BR_IDLE: begin
					if (accept) begin
						state_q   <= data_req_i.wr ? BR_WRITE : BR_RADDR;
						aw_done_q <= 1'b0;
						w_done_q  <= 1'b0;
					end
				end
				BR_RADDR: begin
					if (ar_ready_i) begin
						state_q <= BR_RDATA;
					end
				end
				BR_RDATA: begin
					if (r_valid_i) begin
						state_q <= BR_IDLE;
						done_q  <= 1'b1;
					end
				end
				BR_WRITE: begin
					// aw and w may complete in either order
					aw_done_q <= aw_ok;
					w_done_q  <= w_ok;
					if (aw_ok && w_ok) begin
						state_q <= BR_WRESP;
					end
				end
				BR_WRESP: begin
					if (b_valid_i) begin
						state_q <= BR_IDLE;
						done_q  <= 1'b1;
					end
				end
				default: state_q <= BR_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (accept) begin
			req_q <= data_req_i;
		end
		if (r_valid_i && r_ready_o) begin
			rdata_q <= r_i.data;
		end
	end

endmodule

/* source/inst_fetcher.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module inst_fetcher import mem_pkg::*; (
	input  logic  aclk,
	input  logic  arst_n_i,
	input  logic  fetch_req_i,
	input  addr_t fetch_addr_i,
	output logic  fetch_stall_o,
	output logic  fetch_valid_o,
	output word_t inst1_o,
	output word_t inst2_o,
	output ar_t   ar_o,
	output logic  ar_valid_o,
	input  logic  ar_ready_i,
	input  r_t    r_i,
	input  logic  r_valid_i,
	output logic  r_ready_o
);

	localparam axi_size_t WORD_SIZE = axi_size_t'($clog2(`MEM_STRB_W));
	localparam addr_t ALIGN_MASK = addr_t'((1 << `MEM_FETCH_ALIGN) - 1);

	fetch_state_e state_q;
	addr_t addr_q;
	word_t inst1_q;
	word_t inst2_q;
	logic beat_q;
	logic valid_q;
	logic accept;
	logic ar_fire;
	logic r_fire;

	assign accept  = (state_q == FETCH_IDLE) && fetch_req_i;
	assign ar_fire = ar_valid_o && ar_ready_i;
	assign r_fire  = r_valid_i && r_ready_o;

	assign ar_o = '{
		id:   axi_id_t'(`MEM_ID_FETCH),
		addr: addr_q,
		len:  axi_len_t'(`MEM_FETCH_BEATS - 1),
		size: WORD_SIZE
	};
	assign ar_valid_o = (state_q == FETCH_ADDR);
	assign r_ready_o  = (state_q == FETCH_DATA);

	// busy until the valid pulse, never both at once
	assign fetch_stall_o = (state_q != FETCH_IDLE);
	assign fetch_valid_o = valid_q;
	assign inst1_o       = inst1_q;
	assign inst2_o       = inst2_q;

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= FETCH_IDLE;
			beat_q  <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state_q)
				FETCH_IDLE: begin
					if (accept) begin
						state_q <= FETCH_ADDR;
						beat_q  <= 1'b0;
					end
				end
				FETCH_ADDR: begin
					if (ar_fire) begin
						state_q <= FETCH_DATA;
					end
				end
				FETCH_DATA: begin
					if (r_fire) begin
						beat_q <= ~beat_q;
						if (r_i.last) begin
							state_q <= FETCH_IDLE;
							valid_q <= 1'b1;
						end
					end
				end
				default: state_q <= FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (accept) begin
			addr_q <= fetch_addr_i & ~ALIGN_MASK;
		end
		// first beat is the lower word of the pair
		if (r_fire && !beat_q) begin
			inst1_q <= r_i.data;
		end
		if (r_fire && beat_q) begin
			inst2_q <= r_i.data;
		end
	end

endmodule

/* source/mem_pkg.sv */
`include "mem_params.svh"

package mem_pkg;

	typedef logic [`MEM_ADDR_W-1:0] addr_t;
	typedef logic [`MEM_DATA_W-1:0] word_t;
	typedef logic [`MEM_STRB_W-1:0] strb_t;
	typedef logic [`MEM_ID_W-1:0]   axi_id_t;
	typedef logic [2:0]             axi_size_t;
	typedef logic [3:0]             axi_len_t;
	typedef logic [1:0]             axi_resp_t;

	typedef struct packed {
		axi_id_t   id;
		addr_t     addr;
		axi_len_t  len;
		axi_size_t size;
	} ar_t;

	// write address carries the same fields
	typedef ar_t aw_t;

	typedef struct packed {
		axi_id_t   id;
		word_t     data;
		axi_resp_t resp;
		logic      last;
	} r_t;

	typedef struct packed {
		word_t data;
		strb_t strb;
		logic  last;
	} w_t;

	typedef struct packed {
		axi_id_t   id;
		axi_resp_t resp;
	} b_t;

	typedef struct packed {
		addr_t     addr;
		word_t     wdata;
		strb_t     strb;
		axi_size_t size;
		logic      wr;
	} data_req_t;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_ADDR,
		FETCH_DATA
	} fetch_state_e;

	typedef enum logic [2:0] {
		BR_IDLE,
		BR_RADDR,
		BR_RDATA,
		BR_WRITE,
		BR_WRESP
	} bridge_state_e;

endpackage

/* source/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32
`define MEM_STRB_W 4

// transaction ids
`define MEM_ID_W 4

// rid routing in the read arbiter keys on this value
`define MEM_ID_FETCH 0
`define MEM_ID_DATA 1

// instruction pair per fetch burst
`define MEM_FETCH_BEATS 2

// low address bits cleared on a fetch, 8-byte pairs
`define MEM_FETCH_ALIGN 3

`endif
